//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = fetch_unit_tb
FILELIST  = sim.f
OBJ_DIR   = obj_dir
SIM_BIN   = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '>>> PASS'

clean:
	rm -rf $(OBJ_DIR)

//--- sim.f
verilog/isa_pkg.sv
verilog/fetch_pkg.sv
verilog/fetch_control.sv
verilog/instruction_memory.sv
verilog/branch_predictor.sv
verilog/fetch_unit.sv
verification/fetch_unit_assert.sv
verification/fetch_unit_tb.sv

//--- verification/fetch_unit_assert.sv
`timescale 1ns/1ns

module fetch_control_assert (
  input logic                           clk,
  input logic                           reset,
  input logic                           stall,
  input logic                           flush,
  input logic                           branch_taken,
  input logic [isa_pkg::addr_width-1:0] pc,
  input logic [isa_pkg::addr_width-1:0] pc0,
  input logic [isa_pkg::addr_width-1:0] pc1
);

  ////////////////////////////////////////////////////////////
  // reset

  taken_clear_after_reset: assert property (
    @(posedge clk) reset |=> !branch_taken
  ) else $error("branch_taken set in the cycle after reset");

  ////////////////////////////////////////////////////////////
  // stall

  stall_holds_pc: assert property (
    @(posedge clk) disable iff (reset)
    (stall && !flush) |=> (pc == $past(pc))
  ) else $error("pc moved during a stall");

  ////////////////////////////////////////////////////////////
  // slot addresses

  slot_pcs_adjacent: assert property (
    @(posedge clk) disable iff (reset)
    pc1 == (pc0 + 16'd1)
  ) else $error("pc1 is not pc0 plus one");

endmodule

bind fetch_control fetch_control_assert fetch_control_assert_inst (
  .clk          (clk),
  .reset        (reset),
  .stall        (stall),
  .flush        (flush),
  .branch_taken (branch_taken),
  .pc           (pc),
  .pc0          (pc0),
  .pc1          (pc1)
);

//--- verification/fetch_unit_tb.sv
`timescale 1ns/1ns

module fetch_unit_tb;

  localparam int aw        = isa_pkg::addr_width;
  localparam int iw        = isa_pkg::inst_width;
  localparam int idw       = fetch_pkg::instruction_id_width;
  localparam int cw        = idw - fetch_pkg::num_bits_pipe_id;
  localparam int entries   = 16;
  localparam int mem_words = 256;

  logic clk = 1'b0;
  logic reset, stall, flush, hazard_flush0, hazard_flush1;
  logic [aw-1:0] branch_address, address, decode_pc;
  logic [isa_pkg::op_code_bits-1:0] opcode;
  logic resolve_valid, resolve_taken, load_en;
  logic [aw-1:0] resolve_pc, resolve_target, load_addr;
  logic [iw-1:0] load_data;
  logic [aw-1:0] pc0, pc1, branch_taken_address;
  logic [idw-1:0] id0, id1;
  logic [iw-1:0] instruction0, instruction1;
  logic branch_taken;

  // reference model state
  logic [aw-1:0] exp_pc, exp_taken_addr;
  logic [cw-1:0] exp_count;
  logic          exp_taken;
  logic [iw-1:0] mem_model [mem_words];
  logic [1:0]    ctr_model [entries];
  logic [aw-1:0] tgt_model [entries];

  logic [31:0] rand_state = 32'h369d3b31;
  logic        check_on   = 1'b0;
  int          error_count = 0;
  int          tests_run   = 0;

  always #50 clk = ~clk;

  fetch_unit #(
    .predictor_entries (entries),
    .mem_depth         (mem_words)
  ) fetch_unit_inst (.*);

  //////////////////////////////////////////////////////////////
  // compare tasks

  task automatic check_addr(input string name, input logic [aw-1:0] got, input logic [aw-1:0] exp);
    if (got !== exp) begin
      $display("ERROR %s: got %h expected %h", name, got, exp);
      error_count++;
    end
  endtask

  task automatic check_inst(input string name, input logic [iw-1:0] got, input logic [iw-1:0] exp);
    if (got !== exp) begin
      $display("ERROR %s: got %h expected %h", name, got, exp);
      error_count++;
    end
  endtask

  task automatic check_id(input string name, input logic [idw-1:0] got, input logic [idw-1:0] exp);
    if (got !== exp) begin
      $display("ERROR %s: got %h expected %h", name, got, exp);
      error_count++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERROR %s: got %h expected %h", name, got, exp);
      error_count++;
    end
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  //////////////////////////////////////////////////////////////
  // model checks the current state and then steps it with the held inputs

  always @(negedge clk) begin
    logic jmp;
    logic br;
    logic [3:0] li;
    logic [3:0] ti;
    logic [aw-1:0] pc_plus1;
    jmp = (opcode == isa_pkg::op_code_jmp);
    br  = ((opcode & isa_pkg::branch_class) == isa_pkg::branch_class) && !jmp;
    li  = decode_pc[3:0];
    ti  = resolve_pc[3:0];
    pc_plus1 = exp_pc + 16'd1;
    if (check_on) begin
      check_addr("pc0", pc0, exp_pc);
      check_addr("pc1", pc1, pc_plus1);
      check_id("id0", id0, {exp_count, 2'd1});
      check_id("id1", id1, {exp_count, 2'd2});
      check_inst("instruction0", instruction0, hazard_flush0 ? '0 : mem_model[exp_pc[7:0]]);
      check_inst("instruction1", instruction1, hazard_flush1 ? '0 : mem_model[pc_plus1[7:0]]);
      check_flag("branch_taken", branch_taken, exp_taken);
      check_addr("branch_taken_address", branch_taken_address, exp_taken_addr);
    end
    if (load_en) mem_model[load_addr[7:0]] = load_data;
    if (reset) begin
      exp_pc = '0;
      exp_count = '0;
      exp_taken = 1'b0;
      exp_taken_addr = '0;
      for (int i = 0; i < entries; i++) begin
        ctr_model[i] = 2'b01; // weakly not taken
        tgt_model[i] = '0;
      end
    end else begin
      exp_count = exp_count + 1'b1;
      if (flush) begin
        exp_pc = branch_address;
        exp_taken = 1'b0;
      end else if (!stall) begin
        if (jmp) begin
          exp_pc = address;
          exp_taken = 1'b0;
        end else if (br && ctr_model[li][1]) begin
          exp_pc = tgt_model[li];
          exp_taken = 1'b1;
          exp_taken_addr = tgt_model[li];
        end else begin
          exp_pc = exp_pc + 16'd2;
          exp_taken = 1'b0;
        end
      end
      if (resolve_valid && resolve_taken) begin
        if (ctr_model[ti] != 2'b11) ctr_model[ti] = ctr_model[ti] + 2'd1;
        tgt_model[ti] = resolve_target;
      end else if (resolve_valid && ctr_model[ti] != 2'b00) begin
        ctr_model[ti] = ctr_model[ti] - 2'd1;
      end
    end
  end

  //////////////////////////////////////////////////////////////
  // stimulus helpers

  task automatic apply(input logic st, input logic fl, input logic [aw-1:0] baddr,
                       input logic [5:0] op, input logic [aw-1:0] addr,
                       input logic [aw-1:0] dpc, input logic h0, input logic h1);
    @(posedge clk);
    stall <= st;
    flush <= fl;
    branch_address <= baddr;
    opcode <= op;
    address <= addr;
    decode_pc <= dpc;
    hazard_flush0 <= h0;
    hazard_flush1 <= h1;
    resolve_valid <= 1'b0;
  endtask

  task automatic idle(input int n);
    repeat (n) apply(1'b0, 1'b0, '0, 6'd0, '0, '0, 1'b0, 1'b0);
  endtask

  task automatic train(input logic [aw-1:0] rpc, input logic taken, input logic [aw-1:0] tgt);
    apply(1'b0, 1'b0, '0, 6'd0, '0, '0, 1'b0, 1'b0);
    resolve_valid <= 1'b1;
    resolve_pc <= rpc;
    resolve_taken <= taken;
    resolve_target <= tgt;
  endtask

  task automatic wait_for_pc(input logic [aw-1:0] target, input int limit);
    int i;
    for (i = 0; i < limit; i++) begin
      @(negedge clk);
      if (pc0 == target) break;
    end
    if (i == limit) begin
      $display("timeout while waiting for pc0 to reach %h", target);
      error_count++;
    end
  endtask

  task automatic report(input string name, input int errs_before);
    tests_run++;
    if (error_count == errs_before) $display("test %s passed", name);
    else $display("test %s failed with %0d errors", name, error_count - errs_before);
  endtask

  task automatic load_program();
    apply(1'b1, 1'b0, '0, 6'd0, '0, '0, 1'b0, 1'b0); // hold pc while loading
    for (int i = 0; i < mem_words; i++) begin
      @(posedge clk);
      rand_state = xorshift32(rand_state);
      load_en <= 1'b1;
      load_addr <= aw'(i);
      load_data <= rand_state;
    end
    @(posedge clk);
    load_en <= 1'b0;
    check_on = 1'b1;
  endtask

  //////////////////////////////////////////////////////////////
  // directed tests

  task automatic test_sequential();
    int e = error_count;
    idle(1);
    @(negedge clk);
    wait_for_pc(pc0 + 16'd8, 10);
    report("sequential", e);
  endtask

  task automatic test_jump();
    int e = error_count;
    apply(1'b0, 1'b0, '0, isa_pkg::op_code_jmp, 16'h0040, '0, 1'b0, 1'b0);
    idle(1);
    @(negedge clk);
    check_addr("pc0", pc0, 16'h0040);
    check_flag("branch_taken", branch_taken, 1'b0);
    report("jump", e);
  endtask

  task automatic test_branch();
    int e = error_count;
    train(16'h0025, 1'b1, 16'h0080);
    train(16'h0025, 1'b1, 16'h0080);
    apply(1'b0, 1'b0, '0, 6'b110101, '0, 16'h0025, 1'b0, 1'b0);
    idle(1);
    @(negedge clk);
    check_addr("pc0", pc0, 16'h0080);
    check_flag("branch_taken", branch_taken, 1'b1);
    check_addr("branch_taken_address", branch_taken_address, 16'h0080);
    apply(1'b0, 1'b0, '0, 6'b110101, '0, 16'h0026, 1'b0, 1'b0);
    idle(1);
    @(negedge clk);
    check_addr("pc0", pc0, 16'h0084);
    report("branch", e);
  endtask

  task automatic test_priority();
    int e = error_count;
    apply(1'b1, 1'b1, 16'h0010, isa_pkg::op_code_jmp, 16'h0060, '0, 1'b0, 1'b0);
    repeat (3) apply(1'b1, 1'b0, '0, 6'd0, '0, '0, 1'b0, 1'b0);
    @(negedge clk);
    check_addr("pc0", pc0, 16'h0010);
    idle(2);
    report("priority", e);
  endtask

  task automatic test_squash();
    int e = error_count;
    apply(1'b0, 1'b0, '0, 6'd0, '0, '0, 1'b1, 1'b0);
    apply(1'b0, 1'b0, '0, 6'd0, '0, '0, 1'b0, 1'b1);
    @(negedge clk);
    check_inst("instruction1", instruction1, '0);
    idle(1);
    report("squash", e);
  endtask

  task automatic test_reset();
    int e = error_count;
    apply(1'b0, 1'b0, '0, 6'b110101, '0, 16'h0025, 1'b0, 1'b0); // taken branch first
    idle(1);
    reset <= 1'b1;
    @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    check_addr("pc0", pc0, '0);
    check_flag("branch_taken", branch_taken, 1'b0);
    check_id("id0", id0, 16'h0001);
    wait_for_pc(16'h0004, 10);
    report("reset", e);
  endtask

  //////////////////////////////////////////////////////////////

  initial begin
    reset = 1'b1;
    stall = 1'b0;
    flush = 1'b0;
    branch_address = '0;
    hazard_flush0 = 1'b0;
    hazard_flush1 = 1'b0;
    opcode = '0;
    address = '0;
    decode_pc = '0;
    resolve_valid = 1'b0;
    resolve_pc = '0;
    resolve_taken = 1'b0;
    resolve_target = '0;
    load_en = 1'b0;
    load_addr = '0;
    load_data = '0;
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    load_program();
    test_sequential();
    test_jump();
    test_branch();
    test_priority();
    test_squash();
    test_reset();
    $display("tests run %0d, errors %0d", tests_run, error_count);
    if (error_count == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  initial begin
    #200000;
    $display("timeout, the run did not reach its end");
    $display(">>> FAIL");
    $finish;
  end

endmodule

//--- verilog/branch_predictor.sv
`timescale 1ns/1ns

module branch_predictor #(
  parameter int predictor_entries = fetch_pkg::predictor_entries_default
) (
  input  logic                           clk,
  input  logic                           reset,

  input  logic [isa_pkg::addr_width-1:0] decode_pc, // lookup address

  input  logic                           resolve_valid, // training strobe from execute
  input  logic [isa_pkg::addr_width-1:0] resolve_pc,
  input  logic                           resolve_taken,
  input  logic [isa_pkg::addr_width-1:0] resolve_target,

  output logic                           take_branch,
  output logic [isa_pkg::addr_width-1:0] branch_predict
);

  localparam int idx_bits = $clog2(predictor_entries);

  localparam logic [1:0] weak_not_taken = 2'b01;
  localparam logic [1:0] strong_taken   = 2'b11;
  localparam logic [1:0] strong_not     = 2'b00;

  logic [1:0]                     counter [predictor_entries];
  logic [isa_pkg::addr_width-1:0] target  [predictor_entries];

  logic [idx_bits-1:0] lookup_idx;
  logic [idx_bits-1:0] train_idx;

  assign lookup_idx = decode_pc[idx_bits-1:0];
  assign train_idx  = resolve_pc[idx_bits-1:0];

  ////////////////////////////////////////////////////////////
  // training

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < predictor_entries; i++) begin
        counter[i] <= weak_not_taken;
        target[i]  <= '0;
      end
    end else if (resolve_valid) begin
      if (resolve_taken) begin
        if (counter[train_idx] != strong_taken) begin
          counter[train_idx] <= counter[train_idx] + 1'b1;
        end
        target[train_idx] <= resolve_target; // only taken branches carry a target
      end else if (counter[train_idx] != strong_not) begin
        counter[train_idx] <= counter[train_idx] - 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // lookup, combinational

  assign take_branch    = counter[lookup_idx][1]; // upper bit set means taken
  assign branch_predict = target[lookup_idx];

endmodule

//--- verilog/fetch_control.sv
`timescale 1ns/1ns

module fetch_control (
  input  logic                                     clk,
  input  logic                                     reset,

  input  logic                                     stall,
  input  logic                                     flush,          // mispredict
  input  logic [isa_pkg::addr_width-1:0]           branch_address, // corrected pc

  input  logic [isa_pkg::op_code_bits-1:0]         opcode,  // from decode
  input  logic [isa_pkg::addr_width-1:0]           address, // jump target

  input  logic                                     take_branch,    // predictor says taken
  input  logic [isa_pkg::addr_width-1:0]           branch_predict, // predicted target

  input  logic                                     hazard_flush0, // squash slot 0
  input  logic                                     hazard_flush1, // squash slot 1

  input  logic [isa_pkg::inst_width-1:0]           mem_instruction0,
  input  logic [isa_pkg::inst_width-1:0]           mem_instruction1,

  output logic [isa_pkg::addr_width-1:0]           pc, // to instruction memory
  output logic [isa_pkg::addr_width-1:0]           pc0,
  output logic [isa_pkg::addr_width-1:0]           pc1,
  output logic [fetch_pkg::instruction_id_width-1:0] id0,
  output logic [fetch_pkg::instruction_id_width-1:0] id1,
  output logic [isa_pkg::inst_width-1:0]           instruction0,
  output logic [isa_pkg::inst_width-1:0]           instruction1,
  output logic                                     branch_taken,
  output logic [isa_pkg::addr_width-1:0]           branch_taken_address
);

  localparam int count_width =
    fetch_pkg::instruction_id_width - fetch_pkg::num_bits_pipe_id;

  localparam logic [isa_pkg::addr_width-1:0] pc_step = 2; // two words per cycle

  logic [count_width-1:0] cycle_count; // free running, only reset stops it
  logic                   is_jump;
  logic                   is_branch;

  ////////////////////////////////////////////////////////////
  // opcode classification

  assign is_jump   = (opcode == isa_pkg::op_code_jmp);
  assign is_branch = ((opcode & isa_pkg::branch_class) == isa_pkg::branch_class) &&
                     !is_jump;

  ////////////////////////////////////////////////////////////
  // pc and cycle count

  always_ff @(posedge clk) begin
    if (reset) begin
      pc                   <= '0;
      cycle_count          <= '0;
      branch_taken         <= 1'b0;
      branch_taken_address <= '0;
    end else begin
      cycle_count <= cycle_count + 1'b1; // keeps counting through stalls

      if (flush) begin
        pc           <= branch_address;
        branch_taken <= 1'b0;
      end else if (!stall) begin // stall holds pc and the taken flag
        if (is_jump) begin
          pc           <= address;
          branch_taken <= 1'b0;
        end else if (is_branch && take_branch) begin
          pc                   <= branch_predict;
          branch_taken         <= 1'b1;
          branch_taken_address <= branch_predict; // execute checks against this
        end else begin
          pc           <= pc + pc_step;
          branch_taken <= 1'b0;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // slot outputs, same cycle as pc

  assign pc0 = pc;
  assign pc1 = pc + 1'b1;

  assign id0 = {cycle_count, fetch_pkg::pipe_id1};
  assign id1 = {cycle_count, fetch_pkg::pipe_id2};

  assign instruction0 = hazard_flush0 ? isa_pkg::nop_word : mem_instruction0;
  assign instruction1 = hazard_flush1 ? isa_pkg::nop_word : mem_instruction1;

endmodule

//--- verilog/fetch_pkg.sv
package fetch_pkg;

  ////////////////////////////////////////////////////////////
  // logging ids

  localparam int num_bits_pipe_id = 2; // slot tag in the low id bits

  localparam logic [num_bits_pipe_id-1:0] pipe_id1 = 2'd1; // slot 0
  localparam logic [num_bits_pipe_id-1:0] pipe_id2 = 2'd2; // slot 1

  // id = (cycle count << num_bits_pipe_id) | slot tag
  localparam int instruction_id_width = 16;

  ////////////////////////////////////////////////////////////
  // branch predictor

  localparam int predictor_entries_default = 16; // power of two

endpackage

//--- verilog/fetch_unit.sv
`timescale 1ns/1ns

module fetch_unit #(
  parameter int predictor_entries = fetch_pkg::predictor_entries_default,
  parameter int mem_depth         = 2 ** isa_pkg::addr_width
) (
  input  logic                                       clk,
  input  logic                                       reset,

  input  logic                                       stall,
  input  logic                                       flush,
  input  logic [isa_pkg::addr_width-1:0]             branch_address,
  input  logic                                       hazard_flush0,
  input  logic                                       hazard_flush1,

  input  logic [isa_pkg::op_code_bits-1:0]           opcode,
  input  logic [isa_pkg::addr_width-1:0]             address,
  input  logic [isa_pkg::addr_width-1:0]             decode_pc,

  input  logic                                       resolve_valid,
  input  logic [isa_pkg::addr_width-1:0]             resolve_pc,
  input  logic                                       resolve_taken,
  input  logic [isa_pkg::addr_width-1:0]             resolve_target,

  input  logic                                       load_en,
  input  logic [isa_pkg::addr_width-1:0]             load_addr,
  input  logic [isa_pkg::inst_width-1:0]             load_data,

  output logic [isa_pkg::addr_width-1:0]             pc0,
  output logic [isa_pkg::addr_width-1:0]             pc1,
  output logic [fetch_pkg::instruction_id_width-1:0] id0,
  output logic [fetch_pkg::instruction_id_width-1:0] id1,
  output logic [isa_pkg::inst_width-1:0]             instruction0,
  output logic [isa_pkg::inst_width-1:0]             instruction1,
  output logic                                       branch_taken,
  output logic [isa_pkg::addr_width-1:0]             branch_taken_address
);

  logic [isa_pkg::addr_width-1:0] pc;
  logic [isa_pkg::inst_width-1:0] mem_instruction0;
  logic [isa_pkg::inst_width-1:0] mem_instruction1;
  logic                           take_branch;
  logic [isa_pkg::addr_width-1:0] branch_predict;

  ////////////////////////////////////////////////////////////

  fetch_control fetch_control_inst (
    .clk                  (clk),
    .reset                (reset),
    .stall                (stall),
    .flush                (flush),
    .branch_address       (branch_address),
    .opcode               (opcode),
    .address              (address),
    .take_branch          (take_branch),
    .branch_predict       (branch_predict),
    .hazard_flush0        (hazard_flush0),
    .hazard_flush1        (hazard_flush1),
    .mem_instruction0     (mem_instruction0),
    .mem_instruction1     (mem_instruction1),
    .pc                   (pc),
    .pc0                  (pc0),
    .pc1                  (pc1),
    .id0                  (id0),
    .id1                  (id1),
    .instruction0         (instruction0),
    .instruction1         (instruction1),
    .branch_taken         (branch_taken),
    .branch_taken_address (branch_taken_address)
  );

  instruction_memory #(
    .mem_depth (mem_depth)
  ) instruction_memory_inst (
    .clk              (clk),
    .load_en          (load_en),
    .load_addr        (load_addr),
    .load_data        (load_data),
    .pc               (pc),
    .mem_instruction0 (mem_instruction0),
    .mem_instruction1 (mem_instruction1)
  );

  branch_predictor #(
    .predictor_entries (predictor_entries)
  ) branch_predictor_inst (
    .clk            (clk),
    .reset          (reset),
    .decode_pc      (decode_pc),
    .resolve_valid  (resolve_valid),
    .resolve_pc     (resolve_pc),
    .resolve_taken  (resolve_taken),
    .resolve_target (resolve_target),
    .take_branch    (take_branch),
    .branch_predict (branch_predict)
  );

endmodule

//--- verilog/instruction_memory.sv
`timescale 1ns/1ns

module instruction_memory #(
  parameter int mem_depth = 2 ** isa_pkg::addr_width // power of two
) (
  input  logic                           clk,

  input  logic                           load_en, // testbench program load
  input  logic [isa_pkg::addr_width-1:0] load_addr,
  input  logic [isa_pkg::inst_width-1:0] load_data,

  input  logic [isa_pkg::addr_width-1:0] pc,
  output logic [isa_pkg::inst_width-1:0] mem_instruction0,
  output logic [isa_pkg::inst_width-1:0] mem_instruction1
);

  localparam int idx_bits = $clog2(mem_depth);

  logic [isa_pkg::inst_width-1:0] mem [mem_depth];

  logic [idx_bits-1:0] rd_idx0;
  logic [idx_bits-1:0] rd_idx1;

  ////////////////////////////////////////////////////////////
  // load port

  always_ff @(posedge clk) begin
    if (load_en) begin
      mem[load_addr[idx_bits-1:0]] <= load_data; // readable next cycle
    end
  end

  ////////////////////////////////////////////////////////////
  // two adjacent words, asynchronous read

  assign rd_idx0 = pc[idx_bits-1:0];
  assign rd_idx1 = rd_idx0 + 1'b1; // wraps at the array end

  assign mem_instruction0 = mem[rd_idx0];
  assign mem_instruction1 = mem[rd_idx1];

endmodule

//--- verilog/isa_pkg.sv
package isa_pkg;

  ////////////////////////////////////////////////////////////
  // widths

  localparam int addr_width   = 16; // word address, also the pc width
  localparam int inst_width   = 32; // one instruction word
  localparam int op_code_bits = 6;

  ////////////////////////////////////////////////////////////
  // opcodes

  localparam logic [op_code_bits-1:0] op_code_jmp = 6'b110000; // unconditional jump

  // an opcode with both top bits set is a conditional branch,
  // unless it is op_code_jmp itself
  localparam logic [op_code_bits-1:0] branch_class = 6'b110000;

  localparam logic [inst_width-1:0] nop_word = '0; // squashed slot reads as this

endpackage
